/* correlator.f */
+incdir+src
src/corr_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_decoder.sv
src/coincidence_integrator.sv
src/frame_sender.sv
src/pwm_osc.sv
src/correlator.sv
test/correlator_chk.sv
test/correlator_tb.sv

/* test/correlator_tb.sv */
// Correlator testbench
`timescale 1ns/1ps
`include "corr_cfg.svh"

module correlator_tb;

	localparam int NI          = `CORR_NUM_INPUTS;
	localparam int BIT_CLKS    = `CORR_CLKS_PER_BIT;
	localparam int UNIT        = `CORR_WINDOW_UNIT;
	localparam int FRAME_BYTES = 2 + (`CORR_RESOLUTION / 8) * (NI + `CORR_NUM_PAIRS);
	// Wait limits in clocks.
	localparam int RX_WAIT     = 2000;
	localparam int QUIET_WAIT  = 8000;

	logic                 clki;
	logic                 arst_n;
	logic                 rx;
	logic                 tx;
	corr_pkg::line_mask_t pulse_in;
	corr_pkg::line_mask_t pulse_out;
	logic                 integration_clk_pulse;
	corr_pkg::line_mask_t active_line;

	int          cycle;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_err0;
	logic [31:0] lfsr;

	correlator dut_i (
		.clki(clki), .arst_n(arst_n), .rx(rx), .tx(tx), .pulse_in(pulse_in),
		.pulse_out(pulse_out), .integration_clk_pulse(integration_clk_pulse),
		.active_line(active_line)
	);

	initial begin
		clki = 1'b0;
		forever #5 clki = ~clki;
	end

	// Free-running cycle stamp.
	always @(posedge clki) cycle <= cycle + 1;

	// ----------------------------------------------------------------------
	// Compare tasks and bookkeeping.
	// ----------------------------------------------------------------------
	task automatic check_byte(input string name, input corr_pkg::uart_byte_t got,
		input corr_pkg::uart_byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input corr_pkg::count_t got,
		input corr_pkg::count_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_lines(input string name, input corr_pkg::line_mask_t got,
		input corr_pkg::line_mask_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic fail(input string msg);
		errors++;
		$display("error: %s", msg);
	endtask

	task automatic start_test();
		test_err0 = errors;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (errors == test_err0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
		end
	endtask

	// Galois LFSR, one step per bit.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// ----------------------------------------------------------------------
	// Serial link model.
	// ----------------------------------------------------------------------
	// Start bit, LSB first data, stop bit.
	task automatic send_byte(input corr_pkg::uart_byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clki);
			rx <= bits[i];
			repeat (BIT_CLKS - 1) @(posedge clki);
		end
		// Let the decoder apply it.
		repeat (2) @(posedge clki);
	endtask

	// Sampled on the falling clock, returns at mid stop bit.
	task automatic recv_byte(output corr_pkg::uart_byte_t b);
		int waited;
		b = '0;
		waited = 0;
		do begin
			@(negedge clki);
			waited++;
		end while (tx !== 1'b0 && waited < RX_WAIT);
		if (tx !== 1'b0) begin
			fail("no start bit on tx before timeout");
			return;
		end
		repeat (BIT_CLKS / 2 - 1) @(negedge clki);
		if (tx !== 1'b0) fail("start bit on tx too short");
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge clki);
			b[i] = tx;
		end
		repeat (BIT_CLKS) @(negedge clki);
		if (tx !== 1'b1) fail("stop bit missing on tx");
	endtask

	// Waits until tx stays high for n clocks.
	task automatic wait_quiet(input int n);
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < n && waited < QUIET_WAIT) begin
			@(negedge clki);
			waited++;
			quiet = (tx === 1'b1) ? quiet + 1 : 0;
		end
		if (quiet < n) fail("tx never went quiet");
	endtask

	task automatic wait_pulse(input int limit, output int stamp);
		int waited;
		waited = 0;
		stamp = 0;
		do begin
			@(negedge clki);
			waited++;
		end while (integration_clk_pulse !== 1'b1 && waited < limit);
		if (integration_clk_pulse !== 1'b1) fail("no integration_clk_pulse before timeout");
		else stamp = cycle;
	endtask

	task automatic drive_lines(input corr_pkg::line_mask_t m);
		@(posedge clki);
		pulse_in <= m;
	endtask

	// Stop integrating and drain any frame in flight.
	task automatic stop_and_flush();
		send_byte(8'h30);
		wait_quiet(3 * 10 * BIT_CLKS);
	endtask

	// Receives one frame.
	// Active lines count full, pairs count full when both lines are active.
	task automatic expect_frame(input corr_pkg::line_mask_t act, input corr_pkg::count_t full,
		input corr_pkg::line_mask_t ovf);
		corr_pkg::uart_byte_t f [FRAME_BYTES];
		corr_pkg::count_t     exp;
		int                   k;
		for (int i = 0; i < FRAME_BYTES; i++) recv_byte(f[i]);
		check_byte("sync byte", f[0], `CORR_SYNC_BYTE);
		for (int i = 0; i < NI; i++) begin
			exp = act[i] ? full : '0;
			check_count($sformatf("line %0d count", i), {f[1 + 2 * i], f[2 + 2 * i]}, exp);
		end
		k = 1 + 2 * NI;
		for (int a = 0; a < NI; a++) begin
			for (int b = a + 1; b < NI; b++) begin
				exp = (act[a] && act[b]) ? full : '0;
				check_count($sformatf("pair %0d%0d count", a, b), {f[k], f[k + 1]}, exp);
				k += 2;
			end
		end
		check_byte("overflow byte", f[FRAME_BYTES - 1], corr_pkg::uart_byte_t'(ovf));
	endtask

	// ----------------------------------------------------------------------
	// Directed tests.
	// ----------------------------------------------------------------------
	task automatic test_reset_idle();
		int                   tx_low;
		int                   icp_high;
		corr_pkg::line_mask_t seen;
		tx_low = 0;
		icp_high = 0;
		seen = '0;
		start_test();
		for (int i = 0; i < 200; i++) begin
			@(negedge clki);
			if (tx !== 1'b1) tx_low++;
			if (integration_clk_pulse !== 1'b0) icp_high++;
			seen |= pulse_out;
		end
		check_lines("pulse_out", seen, '0);
		if (tx_low != 0) fail("tx left idle after reset");
		if (icp_high != 0) fail("integration_clk_pulse seen while idle");
		end_test("reset idle");
	endtask

	task automatic test_line_counts();
		int t1;
		int t2;
		start_test();
		drive_lines(4'b0101);
		send_byte(8'h31);
		wait_pulse(UNIT + 500, t1);
		expect_frame(4'b0101, corr_pkg::count_t'(UNIT), '0);
		wait_pulse(UNIT, t2);
		check_count("pulse spacing", corr_pkg::count_t'(t2 - t1), corr_pkg::count_t'(UNIT));
		end_test("line counts and window spacing");
	endtask

	task automatic test_polarity();
		logic [31:0]          v;
		corr_pkg::line_mask_t pattern;
		corr_pkg::line_mask_t pol;
		corr_pkg::line_mask_t act;
		int                   t1;
		start_test();
		stop_and_flush();
		v = take_bits(NI);
		pattern = v[NI-1:0];
		v = take_bits(NI);
		pol = v[NI-1:0];
		// A line is active where its pattern bit matches its polarity bit.
		for (int i = 0; i < NI; i++) begin
			act[i] = (pattern[i] == pol[i]);
		end
		drive_lines(pattern);
		send_byte({4'h1, pol});
		send_byte(8'h21);
		@(negedge clki);
		check_lines("active_line", active_line, act);
		send_byte(8'h31);
		wait_pulse(2 * UNIT + 500, t1);
		expect_frame(act, corr_pkg::count_t'(2 * UNIT), '0);
		end_test($sformatf("polarity %h pattern %h", pol, pattern));
	endtask

	task automatic test_saturation();
		int t1;
		int waited;
		int ovf_seen;
		start_test();
		stop_and_flush();
		send_byte(8'h1F);
		send_byte(8'h2F);
		drive_lines('1);
		// Integration first, oscillator one command later.
		// Keeps the PWM phase off its all-low end at window close.
		send_byte(8'h31);
		send_byte(8'h33);
		wait_pulse(16 * UNIT + 500, t1);
		expect_frame('1, '1, '1);
		// Through the next window, full flags mute the oscillator.
		waited = 0;
		ovf_seen = 0;
		do begin
			@(negedge clki);
			waited++;
			if (dut_i.overflow === '1) begin
				ovf_seen++;
				check_lines("pulse_out", pulse_out, '0);
			end
		end while (integration_clk_pulse !== 1'b1 && waited < 16 * UNIT + 100);
		if (integration_clk_pulse !== 1'b1) fail("second saturated window never ended");
		if (ovf_seen == 0) fail("overflow flags never set in the second window");
		end_test("saturation");
	endtask

	task automatic test_oscillator();
		int               waited;
		int               high [NI];
		corr_pkg::count_t exp;
		start_test();
		stop_and_flush();
		drive_lines('0);
		send_byte(8'h20);
		send_byte(8'h33);
		waited = 0;
		do begin
			@(negedge clki);
			waited++;
		end while (pulse_out === '0 && waited < 200);
		if (pulse_out === '0) fail("oscillator never started");
		// One full phase period.
		for (int i = 0; i < NI; i++) high[i] = 0;
		for (int c = 0; c < 512; c++) begin
			for (int i = 0; i < NI; i++) high[i] += pulse_out[i];
			@(negedge clki);
		end
		for (int i = 0; i < NI; i++) begin
			exp = corr_pkg::count_t'((i + 1) * `CORR_PWM_STEP * `CORR_PWM_DIVIDER);
			check_count($sformatf("channel %0d high cycles", i), corr_pkg::count_t'(high[i]), exp);
		end
		send_byte(8'h30);
		for (int c = 0; c < 32; c++) begin
			@(negedge clki);
			if (pulse_out !== '0) begin
				check_lines("pulse_out after disable", pulse_out, '0);
				break;
			end
		end
		end_test("test oscillator");
	endtask

	// ----------------------------------------------------------------------
	// Main sequence.
	// ----------------------------------------------------------------------
	initial begin
		arst_n = 1'b0;
		rx = 1'b1;
		pulse_in = '0;
		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err0 = 0;
		lfsr = 32'h7d6c;
		repeat (5) @(posedge clki);
		arst_n <= 1'b1;

		test_reset_idle();
		test_line_counts();
		test_polarity();
		test_saturation();
		test_oscillator();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* test/correlator_chk.sv */
// Correlator bound checker
`timescale 1ns/1ps

module correlator_chk (
	input logic                 clki,
	input logic                 arst_n,
	input logic                 integration_clk_pulse,
	input logic                 tx,
	input logic                 tx_busy,
	input logic                 integrating,
	input corr_pkg::line_mask_t pulse_out,
	input corr_pkg::line_mask_t overflow
);

	// Window end lasts one cycle.
	a_pulse_single: assert property (@(posedge clki) disable iff (!arst_n)
		integration_clk_pulse |=> !integration_clk_pulse)
		else $error("integration_clk_pulse high on two cycles in a row");

	// Idle serial line rests high.
	a_tx_idle: assert property (@(posedge clki) disable iff (!arst_n)
		!tx_busy |-> tx)
		else $error("tx low while the transmitter is idle");

	// Saturated lines get no test pulse.
	a_ovf_mute: assert property (@(posedge clki) disable iff (!arst_n)
		(pulse_out & overflow) == '0)
		else $error("pulse_out active on an overflowed line");

	// Oscillator silent outside a window.
	a_osc_off: assert property (@(posedge clki) disable iff (!arst_n)
		!integrating |-> pulse_out == '0)
		else $error("pulse_out active while not integrating");

endmodule

bind correlator correlator_chk chk_i (.*);

/* src/correlator.sv */
// Correlator top level
`timescale 1ns/1ps
`include "corr_cfg.svh"

module correlator (
	input  logic                 clki,
	input  logic                 arst_n,
	input  logic                 rx,
	output logic                 tx,
	input  corr_pkg::line_mask_t pulse_in,
	output corr_pkg::line_mask_t pulse_out,
	output logic                 integration_clk_pulse,
	output corr_pkg::line_mask_t active_line
);

	corr_pkg::uart_byte_t rx_byte;
	logic                 rx_valid;
	corr_pkg::line_mask_t polarity;
	corr_pkg::win_code_t  win_code;
	logic                 integrate_en;
	logic                 osc_en;
	corr_pkg::line_mask_t in_line;
	logic                 integrating;
	corr_pkg::line_mask_t overflow;
	logic                 snap_valid;
	logic [`CORR_NUM_INPUTS*`CORR_RESOLUTION-1:0] snap_line;
	logic [`CORR_NUM_PAIRS*`CORR_RESOLUTION-1:0]  snap_pair;
	corr_pkg::line_mask_t snap_overflow;
	corr_pkg::uart_byte_t tx_data;
	logic                 tx_start;
	logic                 tx_busy;
	corr_pkg::line_mask_t pwm_out;

	// ----------------------------------------------------------------------
	// Line conditioning.
	// ----------------------------------------------------------------------
	// Polarity 1 passes the line, 0 inverts it.
	assign in_line     = pulse_in ~^ polarity;
	assign active_line = in_line;
	// Saturated lines mute their test pulse.
	assign pulse_out   = pwm_out & ~overflow;

	uart_rx uart_rx_i (
		.clki(clki), .arst_n(arst_n), .rx(rx), .rx_byte(rx_byte), .rx_valid(rx_valid)
	);

	cmd_decoder cmd_decoder_i (
		.clki(clki), .arst_n(arst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
		.polarity(polarity), .win_code(win_code), .integrate_en(integrate_en), .osc_en(osc_en)
	);

	coincidence_integrator integrator_i (
		.clki(clki), .arst_n(arst_n), .in_line(in_line), .win_code(win_code),
		.integrate_en(integrate_en), .integrating(integrating),
		.integration_clk_pulse(integration_clk_pulse), .overflow(overflow),
		.snap_valid(snap_valid), .snap_line(snap_line), .snap_pair(snap_pair),
		.snap_overflow(snap_overflow)
	);

	frame_sender frame_sender_i (
		.clki(clki), .arst_n(arst_n), .snap_valid(snap_valid), .snap_line(snap_line),
		.snap_pair(snap_pair), .snap_overflow(snap_overflow), .tx_busy(tx_busy),
		.tx_data(tx_data), .tx_start(tx_start)
	);

	uart_tx uart_tx_i (
		.clki(clki), .arst_n(arst_n), .tx_data(tx_data), .tx_start(tx_start),
		.tx(tx), .tx_busy(tx_busy)
	);

	// Oscillator only runs inside a window.
	pwm_osc pwm_osc_i (
		.clki(clki), .arst_n(arst_n), .run(integrating & osc_en), .pwm_out(pwm_out)
	);

endmodule

/* src/pwm_osc.sv */
// PWM test pulse generator
`timescale 1ns/1ps
`include "corr_cfg.svh"

module pwm_osc (
	input  logic                 clki,
	input  logic                 arst_n,
	input  logic                 run,
	output corr_pkg::line_mask_t pwm_out
);

	localparam int PHASE_W = 8;
	localparam int DIV_W   = $clog2(`CORR_PWM_DIVIDER + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`CORR_PWM_DIVIDER - 1);

	logic [DIV_W-1:0]   div_cnt;
	logic [PHASE_W-1:0] phase;

	// Phase ramp, held at zero while stopped.
	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			phase   <= '0;
		end else if (!run) begin
			div_cnt <= '0;
			phase   <= '0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
			phase   <= phase + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Channel i duty grows by one step per channel.
	for (genvar i = 0; i < `CORR_NUM_INPUTS; i++) begin : g_chan
		localparam logic [PHASE_W:0] THR = (PHASE_W + 1)'((i + 1) * `CORR_PWM_STEP);
		assign pwm_out[i] = run & ({1'b0, phase} < THR);
	end

endmodule

/* src/frame_sender.sv */
// Snapshot frame serializer
`timescale 1ns/1ps
`include "corr_cfg.svh"

module frame_sender (
	input  logic                                         clki,
	input  logic                                         arst_n,
	input  logic                                         snap_valid,
	input  logic [`CORR_NUM_INPUTS*`CORR_RESOLUTION-1:0] snap_line,
	input  logic [`CORR_NUM_PAIRS*`CORR_RESOLUTION-1:0]  snap_pair,
	input  corr_pkg::line_mask_t                         snap_overflow,
	input  logic                                         tx_busy,
	output corr_pkg::uart_byte_t                         tx_data,
	output logic                                         tx_start
);

	localparam int NI          = `CORR_NUM_INPUTS;
	localparam int NP          = `CORR_NUM_PAIRS;
	localparam int RES         = `CORR_RESOLUTION;
	// Sync byte, counts, overflow byte.
	localparam int FRAME_BYTES = 2 + (RES / 8) * (NI + NP);
	localparam int FRAME_W     = FRAME_BYTES * 8;
	localparam int IDX_W       = $clog2(FRAME_BYTES);
	localparam int LINE_TOP    = FRAME_W - 8;
	localparam int PAIR_TOP    = LINE_TOP - NI * RES;

	logic [FRAME_W-1:0] frame;
	logic [FRAME_W-1:0] frame_buf;
	logic               active;
	logic [IDX_W-1:0]   byte_idx;
	logic               load;
	logic               issue;

	// Snapshot only taken between frames.
	assign load = ~active & snap_valid;
	// One byte per idle transmitter.
	assign issue = active & ~tx_busy & ~tx_start;

	// Frame image, first byte in the top bits.
	// Counts go MSB first.
	always_comb begin
		frame                  = '0;
		frame[FRAME_W-1 -: 8]  = `CORR_SYNC_BYTE;
		for (int i = 0; i < NI; i++) begin
			frame[LINE_TOP - (i + 1) * RES +: RES] = snap_line[i*RES +: RES];
		end
		for (int k = 0; k < NP; k++) begin
			frame[PAIR_TOP - (k + 1) * RES +: RES] = snap_pair[k*RES +: RES];
		end
		frame[NI-1:0] = snap_overflow;
	end

	// ----------------------------------------------------------------------
	// Byte walk.
	// ----------------------------------------------------------------------
	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			active   <= 1'b0;
			byte_idx <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (load) begin
				active   <= 1'b1;
				byte_idx <= '0;
			end else if (issue) begin
				tx_start <= 1'b1;
				byte_idx <= byte_idx + 1'b1;
				// Last byte handed over.
				if (byte_idx == IDX_W'(FRAME_BYTES - 1)) begin
					active <= 1'b0;
				end
			end
		end
	end

	// Frame buffer shifts one byte per issue.
	always_ff @(posedge clki) begin
		if (load) begin
			frame_buf <= frame;
		end else if (issue) begin
			tx_data   <= frame_buf[FRAME_W-1 -: 8];
			frame_buf <= frame_buf << 8;
		end
	end

endmodule

/* src/coincidence_integrator.sv */
// Zero-lag coincidence integrator
`timescale 1ns/1ps
`include "corr_cfg.svh"

module coincidence_integrator (
	input  logic                                           clki,
	input  logic                                           arst_n,
	input  corr_pkg::line_mask_t                           in_line,
	input  corr_pkg::win_code_t                            win_code,
	input  logic                                           integrate_en,
	output logic                                           integrating,
	output logic                                           integration_clk_pulse,
	output corr_pkg::line_mask_t                           overflow,
	output logic                                           snap_valid,
	output logic [`CORR_NUM_INPUTS*`CORR_RESOLUTION-1:0]   snap_line,
	output logic [`CORR_NUM_PAIRS*`CORR_RESOLUTION-1:0]    snap_pair,
	output corr_pkg::line_mask_t                           snap_overflow
);

	localparam int NI      = `CORR_NUM_INPUTS;
	localparam int NP      = `CORR_NUM_PAIRS;
	localparam int RES     = `CORR_RESOLUTION;
	localparam int UNIT_W  = $clog2(`CORR_WINDOW_UNIT);
	localparam int TIMER_W = $bits(corr_pkg::win_code_t) + UNIT_W;

	logic [TIMER_W-1:0]   timer;
	logic [TIMER_W-1:0]   reload;
	corr_pkg::pair_mask_t pair_hit;
	corr_pkg::count_t     line_cnt [NI];
	corr_pkg::count_t     line_nxt [NI];
	corr_pkg::count_t     pair_cnt [NP];
	corr_pkg::count_t     pair_nxt [NP];
	corr_pkg::line_mask_t ovf_nxt;

	// (code + 1) * unit - 1, unit being a power of two.
	assign reload = {win_code, {UNIT_W{1'b1}}};

	// Last cycle of the window.
	assign integration_clk_pulse = integrating & (timer == '0);

	// ----------------------------------------------------------------------
	// Pair products, (0,1),(0,2),(0,3),(1,2),(1,3),(2,3).
	// ----------------------------------------------------------------------
	for (genvar a = 0; a < NI; a++) begin : g_row
		for (genvar b = a + 1; b < NI; b++) begin : g_col
			localparam int K = a * (2 * NI - a - 1) / 2 + b - a - 1;
			assign pair_hit[K] = in_line[a] & in_line[b];
		end
	end

	// Saturating increments.
	// A counter that reaches all ones raises its line flag.
	always_comb begin
		for (int i = 0; i < NI; i++) begin
			line_nxt[i] = line_cnt[i];
			if (in_line[i] && line_cnt[i] != '1) begin
				line_nxt[i] = line_cnt[i] + 1'b1;
			end
			ovf_nxt[i] = overflow[i] | (line_nxt[i] == '1);
		end
		for (int k = 0; k < NP; k++) begin
			pair_nxt[k] = pair_cnt[k];
			if (pair_hit[k] && pair_cnt[k] != '1) begin
				pair_nxt[k] = pair_cnt[k] + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Window timer and live counters.
	// ----------------------------------------------------------------------
	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			integrating <= 1'b0;
			snap_valid  <= 1'b0;
			timer       <= '0;
			overflow    <= '0;
			for (int i = 0; i < NI; i++) line_cnt[i] <= '0;
			for (int k = 0; k < NP; k++) pair_cnt[k] <= '0;
		end else begin
			integrating <= integrate_en;
			snap_valid  <= integration_clk_pulse;
			if (!integrating || integration_clk_pulse) begin
				// Idle or window end, so the next window starts clean.
				timer    <= reload;
				overflow <= '0;
				for (int i = 0; i < NI; i++) line_cnt[i] <= '0;
				for (int k = 0; k < NP; k++) pair_cnt[k] <= '0;
			end else begin
				timer    <= timer - 1'b1;
				overflow <= ovf_nxt;
				for (int i = 0; i < NI; i++) line_cnt[i] <= line_nxt[i];
				for (int k = 0; k < NP; k++) pair_cnt[k] <= pair_nxt[k];
			end
		end
	end

	// Snapshot includes the final cycle's hits.
	always_ff @(posedge clki) begin
		if (integration_clk_pulse) begin
			snap_overflow <= ovf_nxt;
			for (int i = 0; i < NI; i++) snap_line[i*RES +: RES] <= line_nxt[i];
			for (int k = 0; k < NP; k++) snap_pair[k*RES +: RES] <= pair_nxt[k];
		end
	end

endmodule

/* src/cmd_decoder.sv */
// Command decoder
`timescale 1ns/1ps
`include "corr_cfg.svh"

module cmd_decoder (
	input  logic                 clki,
	input  logic                 arst_n,
	input  corr_pkg::uart_byte_t rx_byte,
	input  logic                 rx_valid,
	output corr_pkg::line_mask_t polarity,
	output corr_pkg::win_code_t  win_code,
	output logic                 integrate_en,
	output logic                 osc_en
);

	// Opcodes in the high nibble.
	localparam logic [3:0] OP_POLARITY = 4'h1;
	localparam logic [3:0] OP_WINDOW   = 4'h2;
	localparam logic [3:0] OP_ENABLE   = 4'h3;

	corr_pkg::cmd_state_t state;
	corr_pkg::uart_byte_t cmd_q;

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			state        <= corr_pkg::IDLE;
			cmd_q        <= '0;
			polarity     <= '1;
			win_code     <= '0;
			integrate_en <= 1'b0;
			osc_en       <= 1'b0;
		end else begin
			case (state)
				corr_pkg::IDLE: begin
					// Capture.
					if (rx_valid) begin
						cmd_q <= rx_byte;
						state <= corr_pkg::APPLY;
					end
				end
				corr_pkg::APPLY: begin
					// Low nibble carries the data.
					case (cmd_q[7:4])
						OP_POLARITY: polarity <= corr_pkg::line_mask_t'(cmd_q[3:0]);
						OP_WINDOW:   win_code <= corr_pkg::win_code_t'(cmd_q[3:0]);
						OP_ENABLE: begin
							integrate_en <= cmd_q[0];
							osc_en       <= cmd_q[1];
						end
						// Unknown opcode, no change.
						default: ;
					endcase
					state <= corr_pkg::IDLE;
				end
				default: state <= corr_pkg::IDLE;
			endcase
		end
	end

endmodule

/* src/uart_tx.sv */
// UART transmitter, 8N1
`timescale 1ns/1ps
`include "corr_cfg.svh"

module uart_tx (
	input  logic                 clki,
	input  logic                 arst_n,
	input  corr_pkg::uart_byte_t tx_data,
	input  logic                 tx_start,
	output logic                 tx,
	output logic                 tx_busy
);

	localparam int CNT_W = $clog2(`CORR_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CORR_CLKS_PER_BIT - 1);

	logic             busy_q;
	logic             tx_q;
	logic [8:0]       shreg;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bits_left;

	assign tx = tx_q;
	// Busy already in the start cycle.
	assign tx_busy = busy_q | tx_start;

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			busy_q    <= 1'b0;
			tx_q      <= 1'b1;
			shreg     <= '1;
			baud_cnt  <= '0;
			bits_left <= '0;
		end else if (!busy_q) begin
			if (tx_start) begin
				// Start bit goes out now.
				// Data and stop bit wait in the shifter.
				busy_q    <= 1'b1;
				tx_q      <= 1'b0;
				shreg     <= {1'b1, tx_data};
				baud_cnt  <= FULL_BIT;
				bits_left <= 4'd9;
			end
		end else if (baud_cnt != '0) begin
			baud_cnt <= baud_cnt - 1'b1;
		end else if (bits_left == '0) begin
			// End of stop bit.
			busy_q <= 1'b0;
		end else begin
			tx_q      <= shreg[0];
			shreg     <= {1'b1, shreg[8:1]};
			bits_left <= bits_left - 1'b1;
			baud_cnt  <= FULL_BIT;
		end
	end

endmodule

/* src/uart_rx.sv */
// UART receiver, 8N1
`timescale 1ns/1ps
`include "corr_cfg.svh"

module uart_rx (
	input  logic                 clki,
	input  logic                 arst_n,
	input  logic                 rx,
	output corr_pkg::uart_byte_t rx_byte,
	output logic                 rx_valid
);

	localparam int CNT_W = $clog2(`CORR_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CORR_CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CORR_CLKS_PER_BIT - 1);
	// Bit index of the stop bit, start bit is index 0.
	localparam logic [3:0] STOP_IDX = 4'd9;

	logic [1:0]           rx_sync;
	logic                 rx_s;
	logic                 busy;
	logic [CNT_W-1:0]     baud_cnt;
	logic [3:0]           bit_idx;
	corr_pkg::uart_byte_t shreg;

	// Synchronized line.
	assign rx_s    = rx_sync[1];
	assign rx_byte = shreg;

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			rx_sync  <= 2'b11;
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_idx  <= '0;
			shreg    <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			if (!busy) begin
				// Falling edge opens a frame.
				// First sample lands mid start bit.
				if (!rx_s) begin
					busy     <= 1'b1;
					baud_cnt <= HALF_BIT;
					bit_idx  <= '0;
				end
			end else if (baud_cnt != '0) begin
				baud_cnt <= baud_cnt - 1'b1;
			end else begin
				baud_cnt <= FULL_BIT;
				bit_idx  <= bit_idx + 1'b1;
				if (bit_idx == '0) begin
					// Start bit gone high again, so it was a glitch.
					if (rx_s) begin
						busy <= 1'b0;
					end
				end else if (bit_idx == STOP_IDX) begin
					// Bad stop bit drops the byte.
					busy     <= 1'b0;
					rx_valid <= rx_s;
				end else begin
					// Data bits, LSB first.
					shreg <= {rx_s, shreg[7:1]};
				end
			end
		end
	end

endmodule

/* src/corr_pkg.sv */
// Correlator shared types
`include "corr_cfg.svh"

package corr_pkg;

	// One bit per detector line.
	typedef logic [`CORR_NUM_INPUTS-1:0] line_mask_t;

	// One bit per line pair, (0,1) first and (2,3) last.
	typedef logic [`CORR_NUM_PAIRS-1:0] pair_mask_t;

	// Saturating counter value.
	typedef logic [`CORR_RESOLUTION-1:0] count_t;

	// Serial byte.
	typedef logic [7:0] uart_byte_t;

	// Window length code.
	// Window is (code + 1) units long.
	typedef logic [3:0] win_code_t;

	// Command decoder states.
	typedef enum logic {
		IDLE,
		APPLY
	} cmd_state_t;

endpackage

/* src/corr_cfg.svh */
// Correlator build constants
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

// ----------------------------------------------------------------------
// Array size and counter width.
// ----------------------------------------------------------------------
`define CORR_NUM_INPUTS   4
`define CORR_NUM_PAIRS    6
`define CORR_RESOLUTION   16

// ----------------------------------------------------------------------
// Serial link and timing.
// ----------------------------------------------------------------------
// Clocks per UART bit.
`define CORR_CLKS_PER_BIT 16
// Clocks per window code step, a power of two.
`define CORR_WINDOW_UNIT  4096
// First byte of every frame.
`define CORR_SYNC_BYTE    8'hA5

// Test oscillator.
`define CORR_PWM_DIVIDER  2
`define CORR_PWM_STEP     48

`endif
